/* compile.f */
rtl/cpuPkg.sv
rtl/unifiedMemory.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/decoder.sv
rtl/processor.sv
sim/processor_asserts.sv
sim/processorTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
	--top-module processorTb \
	-f compile.f \
	-o simProcessor

# A failing run may still leave a useful log, so the grep decides
./obj_dir/simProcessor +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
	echo "Result: PASS"
	exit 0
else
	echo "Result: FAIL"
	exit 1
fi

/* sim/processorTb.sv */
`default_nettype none

module processorTb;
	import cpuPkg::*;

	localparam int clkPeriod = 8;
	localparam int sampleDelay = 2;
	localparam int resetCycles = 4;
	localparam int progLen = 33;
	localparam int runSteps = 30;
	localparam int dataBase = 128;
	localparam int dataLen = 8;
	localparam int haltPc = 26;

	logic clk;
	logic rst;
	logic [7:0] led;
	cpuTrace_t trace;

	// Program words, constants after the code
	word_t progTable [progLen];

	// ISA reference state
	word_t mReg [regCount];
	word_t mMem [memDepth];
	word_t mPc;
	logic mZ;

	int errorCount;
	int assertFails;
	cpuTrace_t expTrace;

	processor dut (
		.clk(clk),
		.rst(rst),
		.led(led),
		.trace(trace)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Reset, program and data fit well inside this bound
	initial begin
		#(2 * (runSteps + 8) * clkPeriod);
		$display("Watchdog timeout, the test did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	function automatic word_t encR(opcode_e op, regIdx_t rd, regIdx_t rs1, regIdx_t rs2);
		return {op, rd, rs1, rs2, 6'b0};
	endfunction

	function automatic word_t encI(opcode_e op, regIdx_t rd, logic [9:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [31:0] lcgNext(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic noteMismatch(string what, string field, word_t got, word_t exp);
		errorCount++;
		$display("Error at %0t: %s %s is %h, expected %h", $time, what, field, got, exp);
	endtask

	task automatic checkWord(word_t got, word_t exp, string what);
		if (got !== exp) begin
			noteMismatch(what, "value", got, exp);
		end
	endtask

	// Fields that carry no meaning for an instruction are skipped
	task automatic checkTrace(cpuTrace_t got, cpuTrace_t exp, string what);
		if (got.valid !== exp.valid) begin
			noteMismatch(what, "valid", word_t'(got.valid), word_t'(exp.valid));
		end
		if (exp.valid) begin
			if (got.pc !== exp.pc) noteMismatch(what, "pc", got.pc, exp.pc);
			if (got.instr !== exp.instr) noteMismatch(what, "instr", got.instr, exp.instr);
			if (got.regWe !== exp.regWe) begin
				noteMismatch(what, "regWe", word_t'(got.regWe), word_t'(exp.regWe));
			end
			if (got.memWe !== exp.memWe) begin
				noteMismatch(what, "memWe", word_t'(got.memWe), word_t'(exp.memWe));
			end
			if (exp.regWe && got.regDst !== exp.regDst) begin
				noteMismatch(what, "regDst", word_t'(got.regDst), word_t'(exp.regDst));
			end
			if (exp.regWe && got.regData !== exp.regData) begin
				noteMismatch(what, "regData", got.regData, exp.regData);
			end
			if (exp.memWe && got.memAddr !== exp.memAddr) begin
				noteMismatch(what, "memAddr", got.memAddr, exp.memAddr);
			end
			if (exp.memWe && got.memData !== exp.memData) begin
				noteMismatch(what, "memData", got.memData, exp.memData);
			end
		end
	endtask

	// One instruction of the ISA, returns what should retire
	task automatic stepModel(output cpuTrace_t exp);
		word_t ins;
		word_t imm;
		word_t a;
		word_t b;
		word_t nextPc;
		ins = mMem[mPc[7:0]];
		a = mReg[ins[9:8]];
		b = mReg[ins[7:6]];
		imm = {{6{ins[9]}}, ins[9:0]};
		nextPc = mPc + 16'd1;
		exp = '0;
		exp.valid = 1'b1;
		exp.pc = mPc;
		exp.instr = ins;
		exp.regDst = ins[11:10];
		case (opcode_e'(ins[15:12]))
			opAdd: begin
				exp.regWe = 1'b1;
				exp.regData = a + b;
				mZ = (exp.regData == 16'd0);
			end
			opNand: begin
				exp.regWe = 1'b1;
				exp.regData = ~(a & b);
				mZ = (exp.regData == 16'd0);
			end
			opLw: begin
				exp.regWe = 1'b1;
				exp.regData = mMem[a[7:0]];
			end
			opLwa: begin
				exp.regWe = 1'b1;
				exp.regData = mMem[imm[7:0]];
			end
			opSw: begin
				exp.memWe = 1'b1;
				exp.memAddr = a;
				exp.memData = mReg[ins[11:10]];
			end
			opSwa: begin
				exp.memWe = 1'b1;
				exp.memAddr = imm;
				exp.memData = mReg[ins[11:10]];
			end
			opBz: if (mZ) nextPc = mPc + imm;
			opJr: nextPc = a;
			default: ;
		endcase
		if (exp.regWe) mReg[ins[11:10]] = exp.regData;
		if (exp.memWe) mMem[exp.memAddr[7:0]] = exp.memData;
		mPc = nextPc;
	endtask

	task automatic buildProgram();
		progTable[0] = encI(opLwa, 2'd1, 10'd128);  // random word to r1
		progTable[1] = encI(opLwa, 2'd2, 10'd129);  // random word to r2
		progTable[2] = encR(opAdd, 2'd3, 2'd1, 2'd2);  // sum wraps at 16 bits
		progTable[3] = encI(opSwa, 2'd3, 10'd130);  // store sum over word 130
		progTable[4] = encR(opNand, 2'd0, 2'd1, 2'd2);
		progTable[5] = encI(opLwa, 2'd3, 10'd27);  // r3 = 131
		progTable[6] = encR(opSw, 2'd0, 2'd3, 2'd0);  // mem[131] = r0
		progTable[7] = encR(opLw, 2'd1, 2'd3, 2'd0);  // reads back word 131
		progTable[8] = encI(opLwa, 2'd2, 10'd130);  // reads back the SWA
		progTable[9] = encI(opLwa, 2'd3, 10'd28);  // r3 = 132
		progTable[10] = encR(opLw, 2'd2, 2'd3, 2'd0);  // random word by register address
		progTable[11] = encI(opLwa, 2'd0, 10'd29);  // r0 = all ones
		progTable[12] = encR(opNand, 2'd1, 2'd0, 2'd0);  // zero result sets the flag
		progTable[13] = encI(opBz, 2'd0, 10'd2);  // taken, to 15
		progTable[14] = encR(opAdd, 2'd2, 2'd2, 2'd2);  // skipped
		progTable[15] = encR(opNand, 2'd1, 2'd1, 2'd1);  // nonzero, flag clears
		progTable[16] = encI(opBz, 2'd0, 10'd5);  // not taken
		progTable[17] = encI(opLwa, 2'd1, 10'd30);  // r1 = 1
		progTable[18] = encI(opLwa, 2'd2, 10'd29);  // r2 = -1
		progTable[19] = encR(opAdd, 2'd2, 2'd2, 2'd1);  // loop top
		progTable[20] = encI(opBz, 2'd0, 10'h3ff);  // back to 19 once
		progTable[21] = encI(opLwa, 2'd3, 10'd31);  // r3 = 24
		progTable[22] = encR(opJr, 2'd0, 2'd3, 2'd0);  // jump over 23
		progTable[23] = encR(opAdd, 2'd0, 2'd0, 2'd0);  // skipped
		progTable[24] = encI(opSwa, 2'd2, 10'd133);  // loop count leaves r2 = 1
		progTable[25] = encI(opLwa, 2'd3, 10'd32);  // r3 = 26
		progTable[26] = encR(opJr, 2'd0, 2'd3, 2'd0);  // spins on itself
		progTable[27] = 16'd131;
		progTable[28] = 16'd132;
		progTable[29] = 16'hffff;
		progTable[30] = 16'd1;
		progTable[31] = 16'd24;
		progTable[32] = 16'd26;
	endtask

	// Same image goes to the model and to the DUT memory
	task automatic loadMemory();
		logic [31:0] seed;
		seed = 32'h4a7a;
		for (int a = 0; a < memDepth; a++) begin
			mMem[a] = {~a[7:0], a[7:0]};
		end
		for (int i = 0; i < progLen; i++) begin
			mMem[i] = progTable[i];
		end
		for (int i = 0; i < dataLen; i++) begin
			seed = lcgNext(seed);
			mMem[dataBase + i] = seed[31:16];
		end
		for (int a = 0; a < memDepth; a++) begin
			dut.memory.words[a] = mMem[a];
		end
	endtask

	initial begin
		rst = 1'b1;
		errorCount = 0;
		mPc = '0;
		mZ = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			mReg[i] = '0;
		end
		buildProgram();
		loadMemory();

		// Nothing retires while reset is held
		repeat (resetCycles - 1) begin
			@(negedge clk);
			#sampleDelay;
			expTrace = '0;
			checkTrace(trace, expTrace, "reset");
			checkWord({8'h00, led}, 16'h0000, "led in reset");
		end
		@(negedge clk);
		rst = 1'b0;

		for (int step = 0; step < runSteps; step++) begin
			if (step > 0) begin
				@(negedge clk);
			end
			#sampleDelay;
			checkWord({8'h00, led}, {8'h00, mPc[7:0]}, "led");
			stepModel(expTrace);
			checkTrace(trace, expTrace, "retire");
		end

		checkWord(trace.pc, word_t'(haltPc), "final pc");
		for (int i = 0; i < dataLen; i++) begin
			checkWord(dut.memory.words[dataBase + i], mMem[dataBase + i], "data word");
		end

		assertFails = dut.asserts.failCount;
		$display("Summary: %0d check errors, %0d assertion failures", errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/processor_asserts.sv */
`default_nettype none

module processorAsserts (
	input logic clk,
	input logic rst,
	input logic regWe,
	input logic memWe,
	input cpuPkg::cpuTrace_t trace
);
	import cpuPkg::*;

	// Read by the testbench summary
	int failCount = 0;

	// First retirement after reset is the word at address zero
	property firstFetchAtZero;
		@(posedge clk) $fell(rst) |-> (trace.valid && trace.pc == word_t'(0));
	endproperty

	property noWriteInReset;
		@(posedge clk) rst |-> !(regWe || memWe);
	endproperty

	firstFetchCheck: assert property (firstFetchAtZero)
		else begin
			failCount++;
			$error("first trace after reset is not a valid fetch at address zero");
		end

	noWriteCheck: assert property (noWriteInReset)
		else begin
			failCount++;
			$error("register or memory write enabled during reset");
		end

endmodule

bind processor processorAsserts asserts (
	.clk(clk),
	.rst(rst),
	.regWe(regWe),
	.memWe(memWe),
	.trace(trace)
);

`default_nettype wire

/* rtl/processor.sv */
`default_nettype none

module processor (
	input logic clk,
	input logic rst,
	output logic [7:0] led,
	output cpuPkg::cpuTrace_t trace
);
	import cpuPkg::*;

	word_t pc;
	word_t nextPc;
	word_t instrWord;

	ctrl_t ctrl;
	word_t imm;

	word_t rdDataA;
	word_t rdDataB;
	word_t aluResult;
	logic zFlag;

	word_t dAddr;
	word_t memRdData;
	word_t wrData;

	logic regWe;
	logic memWe;

	unifiedMemory memory (
		.clk(clk),
		.iAddr(pc),
		.iData(instrWord),
		.dAddr(dAddr),
		.dWe(memWe),
		// Store data always comes from read port B
		.dDataIn(rdDataB),
		.dDataOut(memRdData)
	);

	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.we(regWe),
		.wrIdx(ctrl.regDst),
		.wrData(wrData),
		.rdIdxA(ctrl.rdA),
		.rdIdxB(ctrl.rdB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	alu alu (
		.clk(clk),
		.rst(rst),
		.a(rdDataA),
		.b(rdDataB),
		.op(ctrl.aluOp),
		.flagWe(ctrl.flagWe),
		.result(aluResult),
		.zFlag(zFlag)
	);

	decoder decode (
		.instr(instrWord),
		.zFlag(zFlag),
		.ctrl(ctrl),
		.imm(imm)
	);

	// No state may change while reset is held
	assign regWe = ctrl.regWe && !rst;
	assign memWe = ctrl.memWe && !rst;

	// Data address, register or immediate
	assign dAddr = ctrl.memAddrReg ? rdDataA : imm;

	// Write back source
	assign wrData = ctrl.regSrcMem ? memRdData : aluResult;

	// Next PC select, branch already resolved in the decoder
	always_comb begin
		case (ctrl.nextPcSel)
			pcRelative: nextPc = pc + imm;
			pcRegister: nextPc = rdDataA;
			default: nextPc = pc + word_t'(1);
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	assign led = pc[addrWidth-1:0];

	// Describes the instruction that commits at the coming edge
	always_comb begin
		trace.valid = !rst;
		trace.pc = pc;
		trace.instr = instrWord;
		trace.regWe = regWe;
		trace.regDst = ctrl.regDst;
		trace.regData = wrData;
		trace.memWe = memWe;
		trace.memAddr = dAddr;
		trace.memData = rdDataB;
	end

endmodule

`default_nettype wire

/* rtl/decoder.sv */
`default_nettype none

module decoder (
	input cpuPkg::instr_u instr,
	input logic zFlag,
	output cpuPkg::ctrl_t ctrl,
	output cpuPkg::word_t imm
);
	import cpuPkg::*;

	opcode_e opcode;
	logic immSign;

	// Opcode sits in the same bits in both forms
	assign opcode = instr.r.opcode;

	assign immSign = instr.i.imm[immWidth-1];

	// Immediate is used as an address and as a signed branch offset
	assign imm = {{(wordWidth - immWidth){immSign}}, instr.i.imm};

	always_comb begin
		// Defaults describe a no-operation
		ctrl.nextPcSel = pcIncrement;
		ctrl.regWe = 1'b0;
		ctrl.regDst = instr.r.rd;
		ctrl.regSrcMem = 1'b0;
		ctrl.rdA = instr.r.rs1;
		ctrl.rdB = instr.r.rs2;
		ctrl.aluOp = aluOpAdd;
		ctrl.flagWe = 1'b0;
		ctrl.memWe = 1'b0;
		ctrl.memAddrReg = 1'b0;

		case (opcode)
			// rd = rs1 + rs2
			opAdd: begin
				ctrl.regWe = 1'b1;
				ctrl.aluOp = aluOpAdd;
				ctrl.flagWe = 1'b1;
			end

			// rd = ~(rs1 & rs2)
			opNand: begin
				ctrl.regWe = 1'b1;
				ctrl.aluOp = aluOpNand;
				ctrl.flagWe = 1'b1;
			end

			// rd = mem[rs1]
			opLw: begin
				ctrl.regWe = 1'b1;
				ctrl.regSrcMem = 1'b1;
				ctrl.memAddrReg = 1'b1;
				ctrl.rdA = instr.r.rs1;
			end

			// rd = mem[imm]
			opLwa: begin
				ctrl.regWe = 1'b1;
				ctrl.regDst = instr.i.rd;
				ctrl.regSrcMem = 1'b1;
				ctrl.memAddrReg = 1'b0;
			end

			// mem[rs1] = rd, stored register comes through port B
			opSw: begin
				ctrl.memWe = 1'b1;
				ctrl.memAddrReg = 1'b1;
				ctrl.rdA = instr.r.rs1;
				ctrl.rdB = instr.r.rd;
			end

			// mem[imm] = rd
			opSwa: begin
				ctrl.memWe = 1'b1;
				ctrl.memAddrReg = 1'b0;
				ctrl.rdB = instr.i.rd;
			end

			// Relative jump only while the flag is set
			opBz: begin
				if (zFlag) begin
					ctrl.nextPcSel = pcRelative;
				end else begin
					ctrl.nextPcSel = pcIncrement;
				end
			end

			// pc = rs1
			opJr: begin
				ctrl.nextPcSel = pcRegister;
				ctrl.rdA = instr.r.rs1;
			end

			default: begin
				// Unused codes keep the defaults
				ctrl.nextPcSel = pcIncrement;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu (
	input logic clk,
	input logic rst,
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input logic op,
	input logic flagWe,
	output cpuPkg::word_t result,
	output logic zFlag
);
	import cpuPkg::*;

	word_t sum;
	word_t nandOut;

	// Carry out is dropped, sum wraps modulo 2^16
	assign sum = a + b;
	assign nandOut = ~(a & b);

	assign result = (op == aluOpNand) ? nandOut : sum;

	// Flag follows the last ADD or NAND only
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			zFlag <= 1'b0;
		end else if (flagWe) begin
			zFlag <= (result == '0);
		end
	end

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
`default_nettype none

module registerFile (
	input logic clk,
	input logic rst,
	input logic we,
	input cpuPkg::regIdx_t wrIdx,
	input cpuPkg::word_t wrData,
	input cpuPkg::regIdx_t rdIdxA,
	input cpuPkg::regIdx_t rdIdxB,
	output cpuPkg::word_t rdDataA,
	output cpuPkg::word_t rdDataB
);
	import cpuPkg::*;

	word_t regs [regCount];

	// All registers start from zero
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wrIdx] <= wrData;
		end
	end

	// Port A feeds the ALU, the data address and JR
	assign rdDataA = regs[rdIdxA];

	// Port B feeds the ALU and the store data
	// A value written this cycle shows up only after the edge
	assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

/* rtl/unifiedMemory.sv */
`default_nettype none

module unifiedMemory (
	input logic clk,
	input cpuPkg::word_t iAddr,
	output cpuPkg::word_t iData,
	input cpuPkg::word_t dAddr,
	input logic dWe,
	input cpuPkg::word_t dDataIn,
	output cpuPkg::word_t dDataOut
);
	import cpuPkg::*;

	// Shared storage for code and data
	word_t words [memDepth];

	logic [addrWidth-1:0] iIndex;
	logic [addrWidth-1:0] dIndex;

	// Only the low address bits select a word
	assign iIndex = iAddr[addrWidth-1:0];
	assign dIndex = dAddr[addrWidth-1:0];

	// Fetch port, read in the same cycle
	assign iData = words[iIndex];

	// Data port read is combinational as well
	assign dDataOut = words[dIndex];

	// Store lands at the edge that retires the SW or SWA
	always @(posedge clk) begin
		if (dWe) begin
			words[dIndex] <= dDataIn;
		end
	end

endmodule

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// Datapath and memory sizing
	localparam int wordWidth = 16;
	localparam int memDepth = 256;
	localparam int addrWidth = $clog2(memDepth);
	localparam int regCount = 4;
	localparam int regIdxWidth = $clog2(regCount);

	// Instruction field widths
	localparam int opcodeWidth = 4;
	localparam int immWidth = 10;
	localparam int rUnusedWidth = wordWidth - opcodeWidth - 3 * regIdxWidth;

	// ALU operation select
	localparam logic aluOpAdd = 1'b0;
	localparam logic aluOpNand = 1'b1;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;

	// Codes 8 to 15 are not named and execute as no-operation
	typedef enum logic [opcodeWidth-1:0] {
		opAdd = 4'd0,
		opNand = 4'd1,
		opLw = 4'd2,
		opLwa = 4'd3,
		opSw = 4'd4,
		opSwa = 4'd5,
		opBz = 4'd6,
		opJr = 4'd7
	} opcode_e;

	// Register form, used by ADD, NAND, LW, SW and JR
	typedef struct packed {
		opcode_e opcode;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		logic [rUnusedWidth-1:0] unused;
	} instrR_t;

	// Immediate form, used by LWA, SWA and BZ
	typedef struct packed {
		opcode_e opcode;
		regIdx_t rd;
		logic [immWidth-1:0] imm;
	} instrI_t;

	typedef union packed {
		instrR_t r;
		instrI_t i;
	} instr_u;

	typedef enum logic [1:0] {
		pcIncrement,
		pcRelative,
		pcRegister
	} nextPcSel_e;

	typedef struct packed {
		nextPcSel_e nextPcSel;
		logic regWe;
		regIdx_t regDst;
		// Write back memory data instead of the ALU result
		logic regSrcMem;
		regIdx_t rdA;
		regIdx_t rdB;
		logic aluOp;
		logic flagWe;
		logic memWe;
		// Data address from register A instead of the immediate
		logic memAddrReg;
	} ctrl_t;

	// One record per retired instruction
	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
		logic regWe;
		regIdx_t regDst;
		word_t regData;
		logic memWe;
		word_t memAddr;
		word_t memData;
	} cpuTrace_t;

endpackage

`default_nettype wire
